// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_eyemon_bridge -f src.f \
  --Mdir obj_dir -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "^Test OK$" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

// File: src.f
verilog/eyemon_pkg.sv
verilog/eyemon_csr.sv
verilog/base_master.sv
verilog/eyemon_sequencer.sv
verilog/eyemon_bridge.sv
tb/base_model.sv
tb/tb_eyemon_bridge.sv

// File: tb/base_model.sv
`default_nettype none

module base_model #(
  parameter int CHNL_W = 2
) (
  input  wire                                  reconfig_clk,
  input  wire                                  reset,
  input  wire  [eyemon_pkg::BASE_ADDR_W-1:0]   i_address,
  input  wire  [eyemon_pkg::BASE_DATA_W-1:0]   i_writedata,
  input  wire                                  i_write,
  input  wire                                  i_read,
  output logic                                 o_waitrequest,
  output logic [eyemon_pkg::BASE_DATA_W-1:0]   o_readdata,
  output logic                                 o_irq,
  input  wire                                  i_req,
  output logic                                 o_grant
);

  logic [15:0] mem [logic [21:0]];  // {phys, offset}
  logic [eyemon_pkg::PHYS_CHNL_W-1:0] phys_q;
  logic [11:0] offset_q;
  logic [15:0] data_q;
  logic [2:0]  irq_cnt;
  logic [1:0]  poll_cnt;   // busy polls still to report
  logic        accept;
  logic [2:0]  word;
  integer      seed;

  assign accept = (i_write || i_read) && !o_waitrequest;
  assign word   = i_address[4:2];

  function automatic logic [15:0] mem_read(input logic [21:0] key);
    if (mem.exists(key))
      return mem[key];
    return 16'h0;
  endfunction

  // quad all ones maps to the unmapped channel
  function automatic logic [9:0] map_phys(input logic [31:0] logical);
    logic [8:0] quad;
    logic [CHNL_W+8:0] cat;
    quad = logical[CHNL_W +: 9];
    cat  = {quad, logical[CHNL_W-1:0]};
    if (quad == 9'h1ff)
      return eyemon_pkg::ILLEGAL_PHYS_CHNL;
    return cat[9:0];
  endfunction

  always_comb
  begin
    case (word)
      3'd2:    o_readdata = {22'd0, phys_q};
      3'd3:    o_readdata = {23'd0, (poll_cnt != 2'd0), 8'd0};
      3'd5:    o_readdata = {16'd0, data_q};
      default: o_readdata = '0;
    endcase
  end

  initial
    seed = 2;

  always @(posedge reconfig_clk or posedge reset)
  begin
    if (reset)
    begin
      o_waitrequest <= 1'b0;
      o_irq         <= 1'b0;
      o_grant       <= 1'b0;
      irq_cnt       <= 3'd0;
      poll_cnt      <= 2'd0;
      phys_q        <= '0;
      offset_q      <= '0;
      data_q        <= '0;
    end
    else
    begin
      o_waitrequest <= (($random(seed) & 3) == 0);
      // grant only moves between operations and is held once given
      if (!i_req)
        o_grant <= $random(seed) & 1;
      else if (!o_grant)
        o_grant <= $random(seed) & 1;
      if (irq_cnt != 3'd0)
        irq_cnt <= irq_cnt - 3'd1;
      o_irq <= (irq_cnt > 3'd1);
      if (accept && i_write)
      begin
        case (word)
          3'd1: phys_q   <= map_phys(i_writedata);
          3'd4: offset_q <= i_writedata[11:0];
          3'd5: data_q   <= i_writedata[15:0];
          3'd3:
            if (i_writedata[1:0] != 2'b00)
            begin
              if (i_writedata[0])
                mem[{phys_q, offset_q}] = data_q;
              else
                data_q <= mem_read({phys_q, offset_q});
              irq_cnt  <= 3'd6;
              o_irq    <= 1'b1;
              poll_cnt <= 2'd3;
            end
          default: ;
        endcase
      end
      if (accept && i_read && (word == 3'd3) && (poll_cnt != 2'd0))
        poll_cnt <= poll_cnt - 2'd1;
    end
  end

endmodule

`default_nettype wire

// File: tb/tb_eyemon_bridge.sv
`default_nettype none

module tb_eyemon_bridge;

  logic        reconfig_clk;
  logic        reset;
  logic [2:0]  i_address;
  logic        i_write;
  logic [31:0] i_writedata;
  logic        i_read;
  wire  [31:0] o_readdata;
  wire         o_irq;
  wire  [4:0]  o_base_address;
  wire  [31:0] o_base_writedata;
  wire         o_base_write;
  wire         o_base_read;
  wire         base_waitrequest;
  wire  [31:0] base_readdata;
  wire         base_irq;
  wire         o_base_req;
  wire         base_grant;

  integer      errors;
  integer      seed;
  logic        illegal_op;
  logic        hold_q;
  logic [38:0] bus_q;
  logic [38:0] bus_now;
  logic [31:0] rd;
  logic [8:0]  quad;
  logic [1:0]  chan;
  logic [11:0] offset;
  logic [15:0] data;

  eyemon_bridge #(.NUM_INTERFACES(1)) eyemon_bridge_inst (
    .reconfig_clk       (reconfig_clk),
    .reset              (reset),
    .i_address          (i_address),
    .i_write            (i_write),
    .i_writedata        (i_writedata),
    .i_read             (i_read),
    .o_readdata         (o_readdata),
    .o_irq              (o_irq),
    .o_base_address     (o_base_address),
    .o_base_writedata   (o_base_writedata),
    .o_base_write       (o_base_write),
    .o_base_read        (o_base_read),
    .i_base_waitrequest (base_waitrequest),
    .i_base_readdata    (base_readdata),
    .i_base_irq         (base_irq),
    .o_base_req         (o_base_req),
    .i_base_grant       (base_grant)
  );

  base_model #(.CHNL_W(2)) base_model_inst (
    .reconfig_clk  (reconfig_clk),
    .reset         (reset),
    .i_address     (o_base_address),
    .i_writedata   (o_base_writedata),
    .i_write       (o_base_write),
    .i_read        (o_base_read),
    .o_waitrequest (base_waitrequest),
    .o_readdata    (base_readdata),
    .o_irq         (base_irq),
    .i_req         (o_base_req),
    .o_grant       (base_grant)
  );

  initial
  begin
    reconfig_clk = 1'b0;
    forever #10 reconfig_clk = ~reconfig_clk;
  end

  assign bus_now = {o_base_address, o_base_writedata, o_base_write, o_base_read};

  // base bus rules, sampled on the clock edge
  always @(posedge reconfig_clk)
  begin
    if (reset)
      hold_q <= 1'b0;
    else
    begin
      if (hold_q)
        assert (bus_now == bus_q)
        else
        begin
          errors = errors + 1;
          $display("Mismatch at %0t: base bus got %h expected %h", $time, bus_now, bus_q);
        end
      hold_q <= base_waitrequest && (o_base_write || o_base_read);
      bus_q  <= bus_now;
      assert (!((o_base_write || o_base_read) && !base_grant))
      else
      begin
        errors = errors + 1;
        $display("base strobe high without grant at %0t", $time);
      end
      assert (!((o_base_write || o_base_read) && !o_base_req))
      else
      begin
        errors = errors + 1;
        $display("base strobe high while o_base_req is low at %0t", $time);
      end
      assert (!(illegal_op && o_base_write && ((o_base_address == 5'd16) ||
              (o_base_address == 5'd20))))
      else
      begin
        errors = errors + 1;
        $display("offset or data write for an unmapped channel at %0t", $time);
      end
    end
  end

  // request must be held until the completion interrupt
  assert property (@(posedge reconfig_clk) disable iff (reset)
                   o_base_req |=> (o_base_req || o_irq))
  else
  begin
    errors = errors + 1;
    $display("o_base_req dropped before o_irq at %0t", $time);
  end

  task automatic csr_write(input logic [2:0] addr, input logic [31:0] wdata);
    @(posedge reconfig_clk);
    i_write     <= 1'b1;
    i_address   <= addr;
    i_writedata <= wdata;
    @(posedge reconfig_clk);
    i_write <= 1'b0;
  endtask

  task automatic csr_read(input logic [2:0] addr, output logic [31:0] value);
    @(posedge reconfig_clk);
    i_read    <= 1'b1;
    i_address <= addr;
    @(posedge reconfig_clk);
    i_read <= 1'b0;
    @(negedge reconfig_clk);
    value = o_readdata;
  endtask

  task automatic run_op(input logic is_read);
    int n;
    csr_write(3'd0, is_read ? 32'd2 : 32'd1);
    for (n = 0; n < 3000; n++)
    begin
      @(negedge reconfig_clk);
      if (o_irq)
        break;
    end
    if (n == 3000)
    begin
      $display("timeout waiting for o_irq");
      $display("Test FAILED");
      $finish;
    end
  endtask

  task automatic expect_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got == exp)
    else
    begin
      errors = errors + 1;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [9:0] expected_phys(input logic [8:0] q, input logic [1:0] c);
    logic [10:0] cat;
    cat = {q, c};
    return (q == 9'h1ff) ? 10'h3ff : cat[9:0];
  endfunction

  initial
  begin
    errors      = 0;
    seed        = 2;
    illegal_op  = 1'b0;
    reset       = 1'b1;
    i_address   = 3'd0;
    i_write     = 1'b0;
    i_writedata = 32'd0;
    i_read      = 1'b0;
    repeat (2) @(posedge reconfig_clk);
    reset <= 1'b0;
    @(negedge reconfig_clk);
    assert (!o_irq && !o_base_write && !o_base_read && !o_base_req &&
            (o_readdata == 32'd0))
    else
    begin
      errors = errors + 1;
      $display("outputs not low after reset");
    end

    for (int i = 0; i < 4; i++)
    begin
      quad   = $random(seed) % 9'h1ff;
      chan   = $random(seed);
      offset = $random(seed);
      data   = $random(seed);
      csr_write(3'd1, {21'd0, quad, chan});
      csr_write(3'd2, {20'd0, offset});
      csr_write(3'd3, {16'd0, data});
      run_op(1'b0);
      csr_write(3'd3, 32'd0);  // overwrite so the read must come from the base
      run_op(1'b1);
      csr_read(3'd3, rd);
      expect_value("CSR_DATA", rd, {16'd0, data});
      csr_read(3'd4, rd);
      expect_value("CSR_PHYS", rd, {22'd0, expected_phys(quad, chan)});
      csr_read(3'd0, rd);
      expect_value("CSR_CTRL", rd, 32'd0);
    end

    illegal_op = 1'b1;
    csr_write(3'd1, {21'd0, 9'h1ff, 2'd1});
    run_op(1'b0);
    csr_read(3'd0, rd);
    expect_value("CSR_CTRL", rd, 32'd2);
    csr_read(3'd4, rd);
    expect_value("CSR_PHYS", rd, 32'h3ff);
    illegal_op = 1'b0;

    repeat (4) @(posedge reconfig_clk);
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/base_master.sv
`default_nettype none

module base_master (
  input  wire                                  reconfig_clk,
  input  wire                                  reset,
  input  eyemon_pkg::base_cmd_t                i_cmd,
  output logic [eyemon_pkg::BASE_ADDR_W-1:0]   o_base_address,
  output logic [eyemon_pkg::BASE_DATA_W-1:0]   o_base_writedata,
  output logic                                 o_base_write,
  output logic                                 o_base_read,
  input  wire                                  i_base_waitrequest,
  input  wire  [eyemon_pkg::BASE_DATA_W-1:0]   i_base_readdata,
  output logic                                 o_cmd_done,
  output logic [eyemon_pkg::BASE_DATA_W-1:0]   o_rdata
);

  logic active;
  logic accept;

  assign active = o_base_write | o_base_read;
  assign accept = active & ~i_base_waitrequest;  // slave takes the transfer this edge

  // strobes and done pulse
  always_ff @(posedge reconfig_clk or posedge reset)
  begin
    if (reset)
    begin
      o_base_write <= 1'b0;
      o_base_read  <= 1'b0;
      o_cmd_done   <= 1'b0;
    end
    else
    begin
      o_cmd_done <= accept;
      if (i_cmd.start)
      begin
        o_base_write <= ~i_cmd.is_read;
        o_base_read  <= i_cmd.is_read;
      end
      else if (accept)
      begin
        o_base_write <= 1'b0;
        o_base_read  <= 1'b0;
      end
    end
  end

  // address and data only move on a new command
  always_ff @(posedge reconfig_clk)
  begin
    if (i_cmd.start)
    begin
      o_base_address   <= {i_cmd.reg_sel, 2'b00};  // word to byte address
      o_base_writedata <= i_cmd.wdata;
    end
    if (o_base_read && !i_base_waitrequest)
      o_rdata <= i_base_readdata;
  end

endmodule

`default_nettype wire

// File: verilog/eyemon_bridge.sv
`default_nettype none

module eyemon_bridge #(
  parameter int NUM_INTERFACES = 1
) (
  input  wire                                  reconfig_clk,
  input  wire                                  reset,
  input  wire  [2:0]                           i_address,
  input  wire                                  i_write,
  input  wire  [31:0]                          i_writedata,
  input  wire                                  i_read,
  output logic [31:0]                          o_readdata,
  output logic                                 o_irq,
  output logic [eyemon_pkg::BASE_ADDR_W-1:0]   o_base_address,
  output logic [eyemon_pkg::BASE_DATA_W-1:0]   o_base_writedata,
  output logic                                 o_base_write,
  output logic                                 o_base_read,
  input  wire                                  i_base_waitrequest,
  input  wire  [eyemon_pkg::BASE_DATA_W-1:0]   i_base_readdata,
  input  wire                                  i_base_irq,
  output logic                                 o_base_req,
  input  wire                                  i_base_grant
);

  eyemon_pkg::dprio_req_t req;
  eyemon_pkg::base_cmd_t  cmd;
  logic start;
  logic busy;
  logic done;
  logic error;
  logic [eyemon_pkg::DPRIO_DATA_W-1:0] rdata;
  logic [eyemon_pkg::PHYS_CHNL_W-1:0]  phys;
  logic cmd_done;
  logic [eyemon_pkg::BASE_DATA_W-1:0]  cmd_rdata;

  eyemon_csr #(.NUM_INTERFACES(NUM_INTERFACES)) eyemon_csr_inst (
    .reconfig_clk (reconfig_clk),
    .reset        (reset),
    .i_address    (i_address),
    .i_write      (i_write),
    .i_writedata  (i_writedata),
    .i_read       (i_read),
    .o_readdata   (o_readdata),
    .i_busy       (busy),
    .i_done       (done),
    .i_error      (error),
    .i_rdata      (rdata),
    .i_phys       (phys),
    .o_req        (req),
    .o_start      (start)
  );

  eyemon_sequencer #(.NUM_INTERFACES(NUM_INTERFACES)) eyemon_sequencer_inst (
    .reconfig_clk (reconfig_clk),
    .reset        (reset),
    .i_req        (req),
    .i_start      (start),
    .o_cmd        (cmd),
    .i_cmd_done   (cmd_done),
    .i_cmd_rdata  (cmd_rdata),
    .i_base_irq   (i_base_irq),
    .i_base_grant (i_base_grant),
    .o_base_req   (o_base_req),
    .o_busy       (busy),
    .o_done       (done),
    .o_error      (error),
    .o_rdata      (rdata),
    .o_phys       (phys),
    .o_irq        (o_irq)
  );

  base_master base_master_inst (
    .reconfig_clk       (reconfig_clk),
    .reset              (reset),
    .i_cmd              (cmd),
    .o_base_address     (o_base_address),
    .o_base_writedata   (o_base_writedata),
    .o_base_write       (o_base_write),
    .o_base_read        (o_base_read),
    .i_base_waitrequest (i_base_waitrequest),
    .i_base_readdata    (i_base_readdata),
    .o_cmd_done         (cmd_done),
    .o_rdata            (cmd_rdata)
  );

endmodule

`default_nettype wire

// File: verilog/eyemon_csr.sv
`default_nettype none

module eyemon_csr #(
  parameter int NUM_INTERFACES = 1
) (
  input  wire                                     reconfig_clk,
  input  wire                                     reset,
  input  wire  [2:0]                              i_address,
  input  wire                                     i_write,
  input  wire  [31:0]                             i_writedata,
  input  wire                                     i_read,
  output logic [31:0]                             o_readdata,
  input  wire                                     i_busy,
  input  wire                                     i_done,
  input  wire                                     i_error,
  input  wire  [eyemon_pkg::DPRIO_DATA_W-1:0]     i_rdata,
  input  wire  [eyemon_pkg::PHYS_CHNL_W-1:0]      i_phys,
  output eyemon_pkg::dprio_req_t                  o_req,
  output logic                                    o_start
);

  localparam int CHNL_W = eyemon_pkg::chnl_w(NUM_INTERFACES);
  localparam int CMAX_W = eyemon_pkg::CHNL_MAX_W;
  localparam logic [CMAX_W-1:0] CHNL_MASK = {CMAX_W{1'b1}} >> (CMAX_W - CHNL_W);
  localparam int LOG_PAD = 32 - eyemon_pkg::QUAD_W - CHNL_W;

  eyemon_pkg::dprio_req_t req_q;
  logic error_q;
  logic [eyemon_pkg::DPRIO_DATA_W-1:0] rdata_q;  // last read result
  logic [eyemon_pkg::PHYS_CHNL_W-1:0]  phys_q;   // last mapped channel
  logic ctrl_wr;
  logic start_ok;
  logic [31:0] rd_mux;

  assign ctrl_wr  = i_write && (i_address == eyemon_pkg::CSR_CTRL);
  // o_start covers the cycle before the sequencer raises busy
  assign start_ok = ctrl_wr && (i_writedata[1:0] != 2'b00) && !i_busy && !o_start;
  assign o_req    = req_q;

  always_ff @(posedge reconfig_clk or posedge reset)
  begin
    if (reset)
    begin
      o_start    <= 1'b0;
      error_q    <= 1'b0;
      o_readdata <= '0;
    end
    else
    begin
      o_start <= start_ok;
      if (i_done)
        error_q <= i_error;
      if (i_read)
        o_readdata <= rd_mux;
    end
  end

  always_ff @(posedge reconfig_clk)
  begin
    if (start_ok)
      req_q.is_read <= ~i_writedata[0];  // write wins when both set
    if (i_write && (i_address == eyemon_pkg::CSR_LOGICAL))
    begin
      req_q.channel <= i_writedata[CMAX_W-1:0] & CHNL_MASK;
      req_q.quad    <= i_writedata[CHNL_W +: eyemon_pkg::QUAD_W];
    end
    if (i_write && (i_address == eyemon_pkg::CSR_OFFSET))
      req_q.offset <= i_writedata[eyemon_pkg::DPRIO_OFFSET_W-1:0];
    if (i_write && (i_address == eyemon_pkg::CSR_DATA))
      req_q.wdata <= i_writedata[eyemon_pkg::DPRIO_DATA_W-1:0];
    if (i_done)
    begin
      phys_q <= i_phys;
      if (req_q.is_read && !i_error)
        rdata_q <= i_rdata;
    end
  end

  always_comb
  begin
    case (i_address)
      eyemon_pkg::CSR_CTRL:    rd_mux = {30'd0, error_q, i_busy};
      eyemon_pkg::CSR_LOGICAL: rd_mux = {{LOG_PAD{1'b0}}, req_q.quad, req_q.channel[CHNL_W-1:0]};
      eyemon_pkg::CSR_OFFSET:  rd_mux = {{(32 - eyemon_pkg::DPRIO_OFFSET_W){1'b0}}, req_q.offset};
      eyemon_pkg::CSR_DATA:    rd_mux = {{(32 - eyemon_pkg::DPRIO_DATA_W){1'b0}}, rdata_q};
      eyemon_pkg::CSR_PHYS:    rd_mux = {{(32 - eyemon_pkg::PHYS_CHNL_W){1'b0}}, phys_q};
      default:                 rd_mux = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/eyemon_pkg.sv
`default_nettype none

package eyemon_pkg;

  localparam int BASE_DATA_W    = 32;
  localparam int BASE_ADDR_W    = 5;  // word offset << 2 as a byte address
  localparam int DPRIO_DATA_W   = 16;
  localparam int DPRIO_OFFSET_W = 12;
  localparam int QUAD_W         = 9;
  localparam int PHYS_CHNL_W    = 10;
  localparam int CHNL_MAX_W     = 4;  // up to 4 reconfig interfaces
  localparam int BUSY_BIT       = 8;  // busy flag in base control word

  localparam logic [PHYS_CHNL_W-1:0] ILLEGAL_PHYS_CHNL = '1;

  // word offsets on the base reconfig bus
  typedef enum logic [2:0] {
    BASE_LOGICAL   = 3'd1,
    BASE_PHYS      = 3'd2,
    BASE_CONTROL   = 3'd3,
    BASE_OFFSET    = 3'd4,
    BASE_DATA      = 3'd5,
    BASE_BUSY_FLAG = 3'd7
  } base_reg_e;

  // host side register map
  typedef enum logic [2:0] {
    CSR_CTRL    = 3'd0,
    CSR_LOGICAL = 3'd1,
    CSR_OFFSET  = 3'd2,
    CSR_DATA    = 3'd3,
    CSR_PHYS    = 3'd4
  } csr_addr_e;

  typedef enum logic [3:0] {
    IDLE,
    SEND_LOGICAL,
    READ_PHYS,
    CHECK_PHYS,
    SEND_OFFSET,
    SEND_DATA,
    SEND_CONTROL,
    SET_BUSY,
    WAIT_IRQ,
    POLL_BUSY,
    FINISH,
    CLEAR_BUSY
  } seq_state_e;

  typedef struct packed {
    logic                   start;
    logic                   is_read;
    base_reg_e              reg_sel;
    logic [BASE_DATA_W-1:0] wdata;
  } base_cmd_t;

  typedef struct packed {
    logic                      is_read;
    logic [QUAD_W-1:0]         quad;
    logic [CHNL_MAX_W-1:0]     channel;
    logic [DPRIO_OFFSET_W-1:0] offset;
    logic [DPRIO_DATA_W-1:0]   wdata;
  } dprio_req_t;

  // logical channel bits as clog2(4*n) kept within 2..4
  function automatic int chnl_w(input int num_if);
    int w;
    w = $clog2(4 * num_if);
    if (w < 2)
      w = 2;
    if (w > CHNL_MAX_W)
      w = CHNL_MAX_W;
    return w;
  endfunction

endpackage

`default_nettype wire

// File: verilog/eyemon_sequencer.sv
`default_nettype none

module eyemon_sequencer #(
  parameter int NUM_INTERFACES = 1
) (
  input  wire                                  reconfig_clk,
  input  wire                                  reset,
  input  eyemon_pkg::dprio_req_t               i_req,
  input  wire                                  i_start,
  output eyemon_pkg::base_cmd_t                o_cmd,
  input  wire                                  i_cmd_done,
  input  wire  [eyemon_pkg::BASE_DATA_W-1:0]   i_cmd_rdata,
  input  wire                                  i_base_irq,
  input  wire                                  i_base_grant,
  output logic                                 o_base_req,
  output logic                                 o_busy,
  output logic                                 o_done,
  output logic                                 o_error,
  output logic [eyemon_pkg::DPRIO_DATA_W-1:0]  o_rdata,
  output logic [eyemon_pkg::PHYS_CHNL_W-1:0]   o_phys,
  output logic                                 o_irq
);

  localparam int CHNL_W = eyemon_pkg::chnl_w(NUM_INTERFACES);
  localparam int DW     = eyemon_pkg::BASE_DATA_W;
  localparam int LOG_PAD = DW - eyemon_pkg::QUAD_W - CHNL_W;

  eyemon_pkg::seq_state_e state;
  eyemon_pkg::dprio_req_t req_q;
  logic pending;  // command out at base_master
  logic issue;
  logic cmd_start_q;
  logic cmd_rd_q;
  eyemon_pkg::base_reg_e cmd_reg_q;
  logic [DW-1:0] cmd_wdata_q;

  logic cmd_valid;
  logic cmd_rd;
  eyemon_pkg::base_reg_e cmd_reg;
  logic [DW-1:0] cmd_wdata;

  assign o_cmd = '{start: cmd_start_q, is_read: cmd_rd_q, reg_sel: cmd_reg_q,
                   wdata: cmd_wdata_q};
  assign issue = cmd_valid && !pending && i_base_grant;

  // base access belonging to each state
  always_comb
  begin
    cmd_valid = 1'b1;
    cmd_rd    = 1'b0;
    cmd_reg   = eyemon_pkg::BASE_CONTROL;
    cmd_wdata = '0;
    case (state)
      eyemon_pkg::SEND_LOGICAL:
      begin
        cmd_reg   = eyemon_pkg::BASE_LOGICAL;
        cmd_wdata = {{LOG_PAD{1'b0}}, req_q.quad, req_q.channel[CHNL_W-1:0]};
      end
      eyemon_pkg::READ_PHYS:
      begin
        cmd_rd  = 1'b1;
        cmd_reg = eyemon_pkg::BASE_PHYS;
      end
      eyemon_pkg::SEND_OFFSET:
      begin
        cmd_reg   = eyemon_pkg::BASE_OFFSET;
        cmd_wdata = {{(DW - eyemon_pkg::DPRIO_OFFSET_W){1'b0}}, req_q.offset};
      end
      eyemon_pkg::SEND_DATA:
      begin
        cmd_reg   = eyemon_pkg::BASE_DATA;
        cmd_wdata = {{(DW - eyemon_pkg::DPRIO_DATA_W){1'b0}}, req_q.wdata};
      end
      // bit 0 write, bit 1 read
      eyemon_pkg::SEND_CONTROL: cmd_wdata = {{(DW - 2){1'b0}}, req_q.is_read, ~req_q.is_read};
      eyemon_pkg::SET_BUSY:
      begin
        cmd_reg   = eyemon_pkg::BASE_BUSY_FLAG;
        cmd_wdata = {{(DW - 1){1'b0}}, 1'b1};
      end
      eyemon_pkg::POLL_BUSY: cmd_rd = 1'b1;
      eyemon_pkg::FINISH:
      begin
        cmd_rd  = req_q.is_read;  // write gets a zero ack to control
        cmd_reg = req_q.is_read ? eyemon_pkg::BASE_DATA : eyemon_pkg::BASE_CONTROL;
      end
      eyemon_pkg::CLEAR_BUSY: cmd_reg = eyemon_pkg::BASE_BUSY_FLAG;
      default: cmd_valid = 1'b0;  // idle, check and irq wait issue nothing
    endcase
  end

  always_ff @(posedge reconfig_clk or posedge reset)
  begin
    if (reset)
    begin
      state       <= eyemon_pkg::IDLE;
      pending     <= 1'b0;
      cmd_start_q <= 1'b0;
      o_base_req  <= 1'b0;
      o_busy      <= 1'b0;
      o_done      <= 1'b0;
      o_error     <= 1'b0;
      o_irq       <= 1'b0;
    end
    else
    begin
      cmd_start_q <= issue;
      o_done      <= 1'b0;
      o_irq       <= 1'b0;
      if (issue)
        pending <= 1'b1;
      else if (i_cmd_done)
        pending <= 1'b0;

      case (state)
        eyemon_pkg::IDLE:
          if (i_start)
          begin
            o_busy     <= 1'b1;
            o_base_req <= 1'b1;
            o_error    <= 1'b0;
            state      <= eyemon_pkg::SEND_LOGICAL;
          end
        eyemon_pkg::SEND_LOGICAL:
          if (i_cmd_done)
            state <= eyemon_pkg::READ_PHYS;
        eyemon_pkg::READ_PHYS:
          if (i_cmd_done)
            state <= eyemon_pkg::CHECK_PHYS;
        eyemon_pkg::CHECK_PHYS:
          if (o_phys == eyemon_pkg::ILLEGAL_PHYS_CHNL)
          begin
            o_error    <= 1'b1;  // unmapped channel ends before touching the base
            o_done     <= 1'b1;
            o_irq      <= 1'b1;
            o_busy     <= 1'b0;
            o_base_req <= 1'b0;
            state      <= eyemon_pkg::IDLE;
          end
          else
            state <= eyemon_pkg::SEND_OFFSET;
        eyemon_pkg::SEND_OFFSET:
          if (i_cmd_done)
            state <= req_q.is_read ? eyemon_pkg::SEND_CONTROL : eyemon_pkg::SEND_DATA;
        eyemon_pkg::SEND_DATA:
          if (i_cmd_done)
            state <= eyemon_pkg::SEND_CONTROL;
        eyemon_pkg::SEND_CONTROL:
          if (i_cmd_done)
            state <= eyemon_pkg::SET_BUSY;
        eyemon_pkg::SET_BUSY:
          if (i_cmd_done)
            state <= eyemon_pkg::WAIT_IRQ;
        eyemon_pkg::WAIT_IRQ:
          if (!i_base_irq)  // irq level spans the base operation
            state <= eyemon_pkg::POLL_BUSY;
        eyemon_pkg::POLL_BUSY:
          if (i_cmd_done && !i_cmd_rdata[eyemon_pkg::BUSY_BIT])
            state <= eyemon_pkg::FINISH;  // still busy reissues the read
        eyemon_pkg::FINISH:
          if (i_cmd_done)
            state <= eyemon_pkg::CLEAR_BUSY;
        eyemon_pkg::CLEAR_BUSY:
          if (i_cmd_done)
          begin
            o_done     <= 1'b1;
            o_irq      <= 1'b1;
            o_busy     <= 1'b0;
            o_base_req <= 1'b0;
            state      <= eyemon_pkg::IDLE;
          end
        default: state <= eyemon_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge reconfig_clk)
  begin
    if ((state == eyemon_pkg::IDLE) && i_start)
      req_q <= i_req;
    if (issue)
    begin
      cmd_rd_q    <= cmd_rd;
      cmd_reg_q   <= cmd_reg;
      cmd_wdata_q <= cmd_wdata;
    end
    if ((state == eyemon_pkg::READ_PHYS) && i_cmd_done)
      o_phys <= i_cmd_rdata[eyemon_pkg::PHYS_CHNL_W-1:0];
    if ((state == eyemon_pkg::FINISH) && i_cmd_done && req_q.is_read)
      o_rdata <= i_cmd_rdata[eyemon_pkg::DPRIO_DATA_W-1:0];
  end

endmodule

`default_nettype wire
